// ==== lc3b_cpu.f ====
common/lc3b_types.sv
design/stage_register.sv
design/fetch_unit.sv
datapath/control_rom.sv
datapath/regfile.sv
datapath/hazard_unit.sv
datapath/datapath.sv
design/lc3b_cpu.sv
verif/lc3b_cpu_props.sv
verif/lc3b_cpu_tb.sv

// ==== Bender.yml ====
package:
  name: lc3b_cpu

sources:
  - common/lc3b_types.sv
  - design/stage_register.sv
  - design/fetch_unit.sv
  - datapath/control_rom.sv
  - datapath/regfile.sv
  - datapath/hazard_unit.sv
  - datapath/datapath.sv
  - design/lc3b_cpu.sv
  - target: test
    files:
      - verif/lc3b_cpu_props.sv
      - verif/lc3b_cpu_tb.sv

// ==== verif/lc3b_cpu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module lc3b_cpu_tb;
    import lc3b_types::*;

    localparam int clk_period = 8;
    localparam int n_instr = 200;
    localparam lc3b_word reset_pc = 16'h3000;
    localparam lc3b_word final_pc = reset_pc + 16'(2 * (n_instr - 1));
    localparam int watchdog_ns = (8 + n_instr * 12) * clk_period;

    logic clk = 1'b0;
    logic rst;
    logic i_mem_resp;
    logic d_mem_resp;
    lc3b_word instr_rdata;
    lc3b_word mem_rdata;
    logic instr_read;
    lc3b_word instr_address;
    logic mem_read;
    logic mem_write;
    lc3b_word mem_address;
    lc3b_word mem_wdata;

    lc3b_word imem [256];
    lc3b_word dmem [32];
    lc3b_word exp_addr [$];         // stores in program order, from the model
    lc3b_word exp_data [$];
    int i_left;
    int d_left = -1;
    int check_count = 0;
    int error_count = 0;
    int store_total = 0;
    int stores_seen = 0;
    int assertion_fails;

    lc3b_cpu #(.reset_pc(reset_pc)) lc3b_cpu_i
    (
        .clk(clk),
        .rst(rst),
        .i_mem_resp(i_mem_resp),
        .d_mem_resp(d_mem_resp),
        .instr_rdata(instr_rdata),
        .mem_rdata(mem_rdata),
        .instr_read(instr_read),
        .instr_address(instr_address),
        .mem_read(mem_read),
        .mem_write(mem_write),
        .mem_address(mem_address),
        .mem_wdata(mem_wdata)
    );

    bind lc3b_cpu lc3b_cpu_props props_i
    (
        .clk(clk),
        .rst(rst),
        .instr_read(instr_read),
        .mem_read(mem_read),
        .mem_write(mem_write),
        .d_mem_resp(d_mem_resp),
        .mem_address(mem_address),
        .mem_wdata(mem_wdata)
    );

    always #(clk_period / 2) clk = ~clk;

    function automatic lc3b_word fill_word(input lc3b_word addr);
        return {addr[7:0] ^ 8'h5c, addr[15:8] ^ 8'ha3} + addr;     // every address bit counts
    endfunction

    function automatic lc3b_word sext(input lc3b_word value, input int bits);
        lc3b_word mask;
        mask = 16'hffff << bits;
        return value[bits - 1] ? (value | mask) : (value & ~mask);
    endfunction

    function automatic int imem_index(input lc3b_word addr);
        lc3b_word offset;
        offset = addr - reset_pc;
        return int'(offset[8:1]);
    endfunction

    task automatic check_word(input string name, input lc3b_word got, input lc3b_word want);
        check_count++;
        assert (got === want)
        else
        begin
            error_count++;
            $display("[FAIL] %s: got %h, expected %h", name, got, want);
        end
    endtask

    task automatic build_program();
        int kind;
        int skip;
        lc3b_reg dr;
        lc3b_reg sa;
        lc3b_reg sb;
        for (int i = 0; i < 256; i++)
            imem[i] = 16'h0000;         // nop past the end
        for (int i = 0; i < n_instr - 1; i++)
        begin
            kind = $urandom % 9;
            dr = 3'($urandom % 7);      // r7 stays zero, base of every load and store
            sa = 3'($urandom);
            sb = 3'($urandom);
            case (kind)
                0: imem[i] = {4'b0001, dr, sa, 3'b000, sb};
                1: imem[i] = {4'b0001, dr, sa, 1'b1, 5'($urandom)};
                2: imem[i] = {4'b0101, dr, sa, 3'b000, sb};
                3: imem[i] = {4'b0101, dr, sa, 1'b1, 5'($urandom)};
                4: imem[i] = {4'b1001, dr, sa, 6'h3f};
                5: imem[i] = {4'b0110, dr, 3'd7, 1'b0, 5'($urandom)};
                6, 7: imem[i] = {4'b0111, sa, 3'd7, 1'b0, 5'($urandom)};
                default:
                begin
                    skip = $urandom % 4;    // forward only
                    if (skip > n_instr - 2 - i)
                        skip = n_instr - 2 - i;
                    imem[i] = {4'b0000, 3'($urandom), 9'(skip)};
                end
            endcase
        end
        imem[n_instr - 1] = 16'h0fff;   // br nzp to itself
    endtask

    task automatic run_model();
        lc3b_word model_regs [8];
        lc3b_word model_mem [32];
        lc3b_nzp cc;
        lc3b_word ir;
        lc3b_word val;
        lc3b_word addr;
        int pc;
        logic writes;
        cc = 3'b000;
        pc = 0;
        for (int r = 0; r < 8; r++)
            model_regs[r] = 16'h0000;
        for (int w = 0; w < 32; w++)
            model_mem[w] = fill_word(16'(2 * w));
        while (pc < n_instr - 1)
        begin
            ir = imem[pc];
            pc++;
            writes = 1'b1;
            addr = model_regs[ir[8:6]] + (sext(ir, 6) << 1);
            case (ir[15:12])
                4'b0001: val = model_regs[ir[8:6]] + (ir[5] ? sext(ir, 5) : model_regs[ir[2:0]]);
                4'b0101: val = model_regs[ir[8:6]] & (ir[5] ? sext(ir, 5) : model_regs[ir[2:0]]);
                4'b1001: val = ~model_regs[ir[8:6]];
                4'b0110: val = model_mem[addr[5:1]];
                4'b0111:
                begin
                    model_mem[addr[5:1]] = model_regs[ir[11:9]];
                    exp_addr.push_back(addr);
                    exp_data.push_back(model_regs[ir[11:9]]);
                    writes = 1'b0;
                end
                default:
                begin
                    if ((cc & ir[11:9]) != 3'b000)
                        pc = pc + int'($signed(sext(ir, 9)));
                    writes = 1'b0;
                end
            endcase
            if (writes)
            begin
                model_regs[ir[11:9]] = val;
                cc = val[15] ? 3'b100 : ((val == 16'h0000) ? 3'b010 : 3'b001);
            end
        end
        store_total = exp_addr.size();
    endtask

    task automatic record_store();
        stores_seen++;
        dmem[mem_address[5:1]] = mem_wdata;
        check_count++;
        assert (exp_addr.size() > 0)
        else
        begin
            error_count++;
            $display("Store to address %h arrived after the model's last store", mem_address);
        end
        if (exp_addr.size() > 0)
        begin
            check_word("mem_address", mem_address, exp_addr.pop_front());
            check_word("mem_wdata", mem_wdata, exp_data.pop_front());
        end
    endtask

    // instruction memory, never two responses in a row
    always @(posedge clk)
    begin
        if (rst || i_mem_resp)
        begin
            i_mem_resp <= 1'b0;         // pc may move at this edge
            i_left = $urandom % 3;
        end
        else if (i_left != 0)
            i_left = i_left - 1;
        else if (instr_read)
        begin
            i_mem_resp <= 1'b1;
            instr_rdata <= imem[imem_index(instr_address)];
        end
    end

    always @(posedge clk)
    begin
        if (rst || d_mem_resp)
        begin
            d_mem_resp <= 1'b0;
            d_left = -1;
        end
        else if (mem_read || mem_write)
        begin
            if (d_left < 0)
                d_left = $urandom % 4;
            if (d_left > 0)
                d_left = d_left - 1;
            else
            begin
                d_mem_resp <= 1'b1;
                d_left = -1;
                if (mem_read)
                    mem_rdata <= dmem[mem_address[5:1]];
                else
                    record_store();
            end
        end
    end

    initial
    begin
        #(watchdog_ns);
        $display("Timeout: the core did not settle in its final loop in time");
        $display("Regression failed");
        $finish;
    end

    initial
    begin
        rst = 1'b1;
        i_mem_resp = 1'b0;
        d_mem_resp = 1'b0;
        instr_rdata = 16'h0000;
        mem_rdata = 16'h0000;
        void'($urandom(32'hee6b));
        for (int w = 0; w < 32; w++)
            dmem[w] = fill_word(16'(2 * w));
        build_program();
        run_model();
        repeat (8)
            @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        check_word("instr_address", instr_address, reset_pc);  // no response seen yet
        check_word("instr_read", 16'(instr_read), 16'h0001);
        check_word("mem_read", 16'(mem_read), 16'h0000);
        check_word("mem_write", 16'(mem_write), 16'h0000);
        while (instr_address != final_pc)
            @(negedge clk);
        // second return to the loop comes from the final branch itself
        repeat (2)
        begin
            while (instr_address == final_pc)
                @(negedge clk);
            while (instr_address != final_pc)
                @(negedge clk);
        end
        check_word("store count", 16'(stores_seen), 16'(store_total));
        assertion_fails = lc3b_cpu_i.props_i.fail_count;
        $display("checks %0d, errors %0d, assertion failures %0d, stores %0d of %0d",
                 check_count, error_count, assertion_fails, stores_seen, store_total);
        if (error_count == 0 && assertion_fails == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule : lc3b_cpu_tb

`default_nettype wire

// ==== verif/lc3b_cpu_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module lc3b_cpu_props
(
    input wire clk,
    input wire rst,
    input wire instr_read,
    input wire mem_read,
    input wire mem_write,
    input wire d_mem_resp,
    input wire lc3b_types::lc3b_word mem_address,
    input wire lc3b_types::lc3b_word mem_wdata
);

    int fail_count = 0;     // assertion failures so far

    no_dual_access: assert property (@(posedge clk) disable iff (rst) !(mem_read && mem_write))
    else
    begin
        fail_count++;
        $error("mem_read and mem_write high in the same cycle");
    end

    // a pending write keeps its address and data
    write_stable: assert property (@(posedge clk) disable iff (rst)
        (mem_write && !d_mem_resp) |=> ($stable(mem_address) && $stable(mem_wdata)))
    else
    begin
        fail_count++;
        $error("mem_address or mem_wdata changed while a write waited for d_mem_resp");
    end

    // fetch request up one cycle after reset and from then on
    fetch_stays_on: assert property (@(posedge clk) disable iff (rst) !rst |=> instr_read)
    else
    begin
        fail_count++;
        $error("instr_read low after reset");
    end

endmodule : lc3b_cpu_props

`default_nettype wire

// ==== design/lc3b_cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module lc3b_cpu
#(
    parameter lc3b_types::lc3b_word reset_pc = 16'h0000
)
(
    input wire clk,
    input wire rst,
    input wire i_mem_resp,
    input wire d_mem_resp,
    input wire lc3b_types::lc3b_word instr_rdata,
    input wire lc3b_types::lc3b_word mem_rdata,
    output logic instr_read,
    output lc3b_types::lc3b_word instr_address,
    output logic mem_read,
    output logic mem_write,
    output lc3b_types::lc3b_word mem_address,
    output lc3b_types::lc3b_word mem_wdata
);
    import lc3b_types::*;

    lc3b_fetch_packet fetch_packet;
    lc3b_fetch_packet dec_packet;
    lc3b_word target;
    logic advance;
    logic bubble;
    logic redirect;

    fetch_unit #(.reset_pc(reset_pc)) fetch
    (
        .clk(clk),
        .rst(rst),
        .advance(advance),
        .bubble(bubble),
        .redirect(redirect),
        .target(target),
        .instr_rdata(instr_rdata),
        .instr_read(instr_read),
        .instr_address(instr_address),
        .packet(fetch_packet)
    );

    // fetch/decode register, held on bubble, killed by a taken branch
    stage_register #(.payload_t(lc3b_fetch_packet)) if_id
    (
        .clk(clk),
        .rst(rst),
        .load(advance && !bubble),
        .flush(advance && redirect),
        .in(fetch_packet),
        .out(dec_packet)
    );

    datapath dp
    (
        .clk(clk),
        .rst(rst),
        .i_mem_resp(i_mem_resp),
        .d_mem_resp(d_mem_resp),
        .packet(dec_packet),
        .mem_rdata(mem_rdata),
        .advance(advance),
        .bubble(bubble),
        .redirect(redirect),
        .target(target),
        .mem_read(mem_read),
        .mem_write(mem_write),
        .mem_address(mem_address),
        .mem_wdata(mem_wdata)
    );

endmodule : lc3b_cpu

`default_nettype wire

// ==== datapath/datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module datapath
(
    input wire clk,
    input wire rst,
    input wire i_mem_resp,
    input wire d_mem_resp,
    input wire lc3b_types::lc3b_fetch_packet packet,
    input wire lc3b_types::lc3b_word mem_rdata,
    output logic advance,
    output logic bubble,
    output logic redirect,
    output lc3b_types::lc3b_word target,
    output logic mem_read,
    output logic mem_write,
    output lc3b_types::lc3b_word mem_address,
    output lc3b_types::lc3b_word mem_wdata
);
    import lc3b_types::*;

    typedef struct packed
    {
        lc3b_control_word ctrl;
        lc3b_word a;
        lc3b_word b;
        lc3b_word imm;
        lc3b_word target;
    } id_ex_t;

    typedef struct packed
    {
        lc3b_control_word ctrl;
        lc3b_word result;           // alu value or data address
        lc3b_word store_data;
    } ex_mem_t;

    typedef struct packed
    {
        lc3b_control_word ctrl;
        lc3b_word result;
        lc3b_word load_data;
    } mem_wb_t;

    lc3b_control_word dec_ctrl;
    lc3b_word reg_a;
    lc3b_word reg_b;
    id_ex_t dec_out;
    id_ex_t exe;
    ex_mem_t exe_out;
    ex_mem_t exm;
    mem_wb_t mem_out;
    mem_wb_t wb;
    logic [1:0] sel_a;
    logic [1:0] sel_b;
    lc3b_word fwd_a;
    lc3b_word fwd_b;
    lc3b_word alu_out;
    lc3b_word wb_value;
    lc3b_nzp cc;
    logic d_done;
    lc3b_word rdata_q;

    control_rom ctrl_rom (.instr(packet.instr), .ctrl(dec_ctrl));

    regfile rf
    (
        .clk(clk),
        .rst(rst),
        .load(wb.ctrl.load_regfile),
        .dest(wb.ctrl.dest),
        .in(wb_value),
        .src_a(dec_ctrl.sr1),
        .src_b(dec_ctrl.sr2),
        .reg_a(reg_a),
        .reg_b(reg_b)
    );

    hazard_unit hazards
    (
        .dec_ctrl(dec_ctrl),
        .exe_ctrl(exe.ctrl),
        .mem_ctrl(exm.ctrl),
        .wb_ctrl(wb.ctrl),
        .sel_a(sel_a),
        .sel_b(sel_b),
        .bubble(bubble)
    );

    always_comb
    begin
        if (bubble)
            dec_out.ctrl = '0;
        else
            dec_out.ctrl = dec_ctrl;
        dec_out.a = reg_a;
        dec_out.b = reg_b;
        if (dec_ctrl.mem_read || dec_ctrl.mem_write)
            dec_out.imm = {{9{packet.instr[5]}}, packet.instr[5:0], 1'b0};   // word offset
        else
            dec_out.imm = {{11{packet.instr[4]}}, packet.instr[4:0]};
        dec_out.target = packet.pc_plus2 + {{6{packet.instr[8]}}, packet.instr[8:0], 1'b0};
    end

    stage_register #(.payload_t(id_ex_t)) id_ex
    (
        .clk(clk), .rst(rst), .load(advance), .flush(advance && redirect),
        .in(dec_out), .out(exe)
    );

    // execute, 1 = memory stage result, 2 = writeback result
    assign fwd_a = (sel_a == 2'd1) ? exm.result : (sel_a == 2'd2) ? wb_value : exe.a;
    assign fwd_b = (sel_b == 2'd1) ? exm.result : (sel_b == 2'd2) ? wb_value : exe.b;

    always_comb
    begin
        case (exe.ctrl.aluop)
            alu_add:  alu_out = fwd_a + (exe.ctrl.imm_sel ? exe.imm : fwd_b);
            alu_and:  alu_out = fwd_a & (exe.ctrl.imm_sel ? exe.imm : fwd_b);
            alu_not:  alu_out = ~fwd_a;
            default:  alu_out = fwd_b;
        endcase
    end

    assign redirect = exe.ctrl.is_branch && ((cc & exe.ctrl.branch_nzp) != 3'b000);
    assign target = exe.target;
    assign exe_out.ctrl = exe.ctrl;
    assign exe_out.result = alu_out;
    assign exe_out.store_data = fwd_b;

    stage_register #(.payload_t(ex_mem_t)) ex_mem
    (
        .clk(clk), .rst(rst), .load(advance), .flush(1'b0),
        .in(exe_out), .out(exm)
    );

    // memory stage, a finished access waits here for the fetch side
    assign advance = i_mem_resp && (d_mem_resp || d_done ||
                                    !(exm.ctrl.mem_read || exm.ctrl.mem_write));
    assign mem_read = exm.ctrl.mem_read && !d_done;
    assign mem_write = exm.ctrl.mem_write && !d_done;   // no repeated store
    assign mem_address = exm.result;
    assign mem_wdata = exm.store_data;

    always_ff @(posedge clk)
    begin
        if (rst || advance)
            d_done <= 1'b0;
        else if (d_mem_resp)
            d_done <= 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (d_mem_resp)
            rdata_q <= mem_rdata;
    end

    assign mem_out.ctrl = exm.ctrl;
    assign mem_out.result = exm.result;
    assign mem_out.load_data = d_done ? rdata_q : mem_rdata;

    stage_register #(.payload_t(mem_wb_t)) mem_wb
    (
        .clk(clk), .rst(rst), .load(advance), .flush(1'b0),
        .in(mem_out), .out(wb)
    );

    assign wb_value = wb.ctrl.mem_read ? wb.load_data : wb.result;

    always_ff @(posedge clk)
    begin
        if (rst)
            cc <= 3'b000;
        else if (wb.ctrl.load_cc)
            cc <= wb_value[15] ? 3'b100 : (wb_value == 16'h0000) ? 3'b010 : 3'b001;
    end

endmodule : datapath

`default_nettype wire

// ==== datapath/hazard_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazard_unit
(
    input wire lc3b_types::lc3b_control_word dec_ctrl,
    input wire lc3b_types::lc3b_control_word exe_ctrl,
    input wire lc3b_types::lc3b_control_word mem_ctrl,
    input wire lc3b_types::lc3b_control_word wb_ctrl,
    output logic [1:0] sel_a,
    output logic [1:0] sel_b,
    output logic bubble
);

    logic mem_fwd;
    logic dec_uses;
    logic load_use;
    logic cc_wait;

    // a load in memory has no data yet, the bubble keeps its users back
    assign mem_fwd = mem_ctrl.load_regfile && !mem_ctrl.mem_read;

    always_comb
    begin
        sel_a = 2'd0;
        sel_b = 2'd0;
        if (wb_ctrl.load_regfile && wb_ctrl.dest == exe_ctrl.sr1)
            sel_a = 2'd2;
        if (wb_ctrl.load_regfile && wb_ctrl.dest == exe_ctrl.sr2)
            sel_b = 2'd2;
        if (mem_fwd && mem_ctrl.dest == exe_ctrl.sr1)
            sel_a = 2'd1;           // younger result wins
        if (mem_fwd && mem_ctrl.dest == exe_ctrl.sr2)
            sel_b = 2'd1;
    end

    assign dec_uses = dec_ctrl.load_regfile || dec_ctrl.mem_write;
    assign load_use = exe_ctrl.mem_read && dec_uses &&
                      (exe_ctrl.dest == dec_ctrl.sr1 || exe_ctrl.dest == dec_ctrl.sr2);
    assign cc_wait = dec_ctrl.is_branch &&
                     (exe_ctrl.load_cc || mem_ctrl.load_cc || wb_ctrl.load_cc);
    assign bubble = load_use || cc_wait;

endmodule : hazard_unit

`default_nettype wire

// ==== datapath/regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regfile
(
    input wire clk,
    input wire rst,
    input wire load,
    input wire lc3b_types::lc3b_reg dest,
    input wire lc3b_types::lc3b_word in,
    input wire lc3b_types::lc3b_reg src_a,
    input wire lc3b_types::lc3b_reg src_b,
    output lc3b_types::lc3b_word reg_a,
    output lc3b_types::lc3b_word reg_b
);
    import lc3b_types::*;

    lc3b_word data [8];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < 8; i++)
                data[i] <= '0;
        end
        else if (load)
            data[dest] <= in;
    end

    // writeback value seen by decode in the same cycle
    assign reg_a = (load && dest == src_a) ? in : data[src_a];
    assign reg_b = (load && dest == src_b) ? in : data[src_b];

endmodule : regfile

`default_nettype wire

// ==== datapath/control_rom.sv ====
`timescale 1ns/1ps
`default_nettype none

module control_rom
(
    input wire lc3b_types::lc3b_word instr,
    output lc3b_types::lc3b_control_word ctrl
);
    import lc3b_types::*;

    always_comb
    begin
        ctrl = '0;
        ctrl.opcode = lc3b_opcode'(instr[15:12]);
        case (instr[15:12])
            op_add, op_and:
            begin
                ctrl.aluop = (instr[15:12] == op_add) ? alu_add : alu_and;
                ctrl.imm_sel = instr[5];        // imm5 form
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc = 1'b1;
                ctrl.dest = instr[11:9];
                ctrl.sr1 = instr[8:6];
                ctrl.sr2 = instr[2:0];
            end
            op_not:
            begin
                ctrl.aluop = alu_not;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc = 1'b1;
                ctrl.dest = instr[11:9];
                ctrl.sr1 = instr[8:6];
            end
            op_ldr:
            begin
                ctrl.aluop = alu_add;       // base plus offset
                ctrl.imm_sel = 1'b1;
                ctrl.mem_read = 1'b1;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc = 1'b1;
                ctrl.dest = instr[11:9];
                ctrl.sr1 = instr[8:6];
            end
            op_str:
            begin
                ctrl.aluop = alu_add;
                ctrl.imm_sel = 1'b1;
                ctrl.mem_write = 1'b1;
                ctrl.sr1 = instr[8:6];
                ctrl.sr2 = instr[11:9];     // store source
            end
            default:
            begin
                // br with nzp 000 never branches, so it stays a no-op
                ctrl.is_branch = (instr[15:12] == op_br) && (instr[11:9] != 3'b000);
                ctrl.branch_nzp = instr[11:9];
            end
        endcase
    end

endmodule : control_rom

`default_nettype wire

// ==== design/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_unit
#(
    parameter lc3b_types::lc3b_word reset_pc = 16'h0000
)
(
    input wire clk,
    input wire rst,
    input wire advance,
    input wire bubble,
    input wire redirect,
    input wire lc3b_types::lc3b_word target,
    input wire lc3b_types::lc3b_word instr_rdata,
    output logic instr_read,
    output lc3b_types::lc3b_word instr_address,
    output lc3b_types::lc3b_fetch_packet packet
);
    import lc3b_types::*;

    lc3b_word pc_plus2;

    assign pc_plus2 = instr_address + 16'd2;

    // instr_address is the pc itself
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            instr_address <= reset_pc;
            instr_read <= 1'b0;
        end
        else
        begin
            instr_read <= 1'b1;         // fetch runs continuously after reset
            if (advance && redirect)
                instr_address <= target;    // taken branch wins over bubble
            else if (advance && !bubble)
                instr_address <= pc_plus2;
        end
    end

    assign packet.instr = instr_rdata;
    assign packet.pc_plus2 = pc_plus2;

endmodule : fetch_unit

`default_nettype wire

// ==== design/stage_register.sv ====
`timescale 1ns/1ps
`default_nettype none

module stage_register
#(
    parameter type payload_t = logic [15:0]
)
(
    input wire clk,
    input wire rst,
    input wire load,
    input wire flush,
    input wire payload_t in,
    output payload_t out
);

    // all-zero payload is a no-op
    always_ff @(posedge clk)
    begin
        if (rst || flush)
            out <= '0;
        else if (load)
            out <= in;
    end

endmodule : stage_register

`default_nettype wire

// ==== common/lc3b_types.sv ====
`default_nettype none

package lc3b_types;

    typedef logic [15:0] lc3b_word;
    typedef logic [2:0] lc3b_reg;
    typedef logic [2:0] lc3b_nzp;       // n, z, p from msb down

    // LC-3b opcode field values
    typedef enum logic [3:0]
    {
        op_br  = 4'b0000,
        op_add = 4'b0001,
        op_and = 4'b0101,
        op_ldr = 4'b0110,
        op_str = 4'b0111,
        op_not = 4'b1001
    } lc3b_opcode;

    typedef enum logic [1:0]
    {
        alu_add  = 2'b00,
        alu_and  = 2'b01,
        alu_not  = 2'b10,
        alu_pass = 2'b11
    } lc3b_aluop;

    // all zeros decodes to a no-op
    typedef struct packed
    {
        lc3b_opcode opcode;
        lc3b_aluop  aluop;
        logic       imm_sel;        // second alu operand from immediate
        logic       mem_read;
        logic       mem_write;
        logic       load_regfile;
        logic       load_cc;
        logic       is_branch;
        lc3b_nzp    branch_nzp;
        lc3b_reg    dest;
        lc3b_reg    sr1;
        lc3b_reg    sr2;            // store source for str
    } lc3b_control_word;

    typedef struct packed
    {
        lc3b_word instr;
        lc3b_word pc_plus2;
    } lc3b_fetch_packet;

endpackage : lc3b_types

`default_nettype wire
